//--- Bender.yml
package:
  name: lotr

sources:
  - common/ringPkg.sv
  - common/lotrCfgPkg.sv
  - common/ringLinkIf.sv
  - tile/tileDecode.sv
  - tile/tileExecute.sv
  - tile/tileResult.sv
  - tile/ringTile.sv
  - hdl/ringGateway.sv
  - hdl/lotr.sv
  - target: test
    files:
      - verification/tbClockGen.sv
      - verification/lotr_props.sv
      - verification/lotrTb.sv

//--- common/lotrCfgPkg.sv
// default sizing of the ring subsystem, picked up by the top level parameters
package lotrCfgPkg;

    //--------------------------------------------------
    // ring sizing
    //--------------------------------------------------
    localparam int NUM_TILE_DEF  = 4;   // tiles on the ring

    // words per tile memory
    localparam int MEM_DEPTH_DEF = 16;

endpackage

//--- common/ringLinkIf.sv
// one ring hop: a single message qualified by valid, no stall path
`timescale 1ns/100ps

interface ringLinkIf;

    logic                        valid;    // one message per valid cycle
    ringPkg::opcodeT             opcode;
    logic [ringPkg::ADDR_W-1:0]  address;  // target tile in the top byte
    logic [ringPkg::DATA_W-1:0]  data;

    // upstream stage drives the message
    modport sender (
        output valid,
        output opcode,
        output address,
        output data
    );

    // downstream stage always takes it
    modport receiver (
        input  valid,
        input  opcode,
        input  address,
        input  data
    );

endinterface

//--- common/ringPkg.sv
// ring message format shared by the gateway, the tiles and the link interface
package ringPkg;

    //--------------------------------------------------
    // field widths
    //--------------------------------------------------
    localparam int ADDR_W   = 32;   // full address field
    localparam int DATA_W   = 32;   // one memory word

    // target tile lives in the top byte of the address
    localparam int ID_MSB   = 31;
    localparam int ID_LSB   = 24;

    // word index starts at the bottom
    localparam int WORD_LSB = 0;

    //--------------------------------------------------
    // opcodes
    //--------------------------------------------------
    // bit 1 set means the message has been answered
    typedef enum logic [1:0] {
        OP_RD_REQ = 2'b00,  // read request from host
        OP_WR_REQ = 2'b01,  // write request from host
        OP_RD_RSP = 2'b10,  // read answered, data = stored word
        OP_WR_RSP = 2'b11   // write answered, data echoed
    } opcodeT;

endpackage

//--- hdl/lotr.sv
// ring top level, gateway plus NUM_TILE tiles chained into one closed ring
`timescale 1ns/100ps

module lotr #(
    parameter int NUM_TILE  = lotrCfgPkg::NUM_TILE_DEF,
    parameter int MEM_DEPTH = lotrCfgPkg::MEM_DEPTH_DEF
) (
    input  logic                       QClk,
    input  logic                       rstN,
    // host requests
    input  logic                       reqValid,
    input  ringPkg::opcodeT            reqOpcode,
    input  logic [ringPkg::ADDR_W-1:0] reqAddress,
    input  logic [ringPkg::DATA_W-1:0] reqData,
    // host responses
    output logic                       rspValid,
    output ringPkg::opcodeT            rspOpcode,
    output logic [ringPkg::ADDR_W-1:0] rspAddress,
    output logic [ringPkg::DATA_W-1:0] rspData,
    output logic                       rspMiss,
    output logic                       ringIdle
);

    //--------------------------------------------------
    // ring links
    //--------------------------------------------------
    // link 0 gateway->tile 0, link NUM_TILE last tile->gateway
    ringLinkIf ringLink [NUM_TILE+1] ();

    ringGateway #(
        .NUM_TILE   (NUM_TILE)
    ) gateway0 (
        .QClk       (QClk),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .reqOpcode  (reqOpcode),
        .reqAddress (reqAddress),
        .reqData    (reqData),
        .ringOut    (ringLink[0]),
        .ringIn     (ringLink[NUM_TILE]),   // closes the loop
        .rspValid   (rspValid),
        .rspOpcode  (rspOpcode),
        .rspAddress (rspAddress),
        .rspData    (rspData),
        .rspMiss    (rspMiss),
        .ringIdle   (ringIdle)
    );

    // tile number is its ring position
    for (genvar tile = 0; tile < NUM_TILE; tile++) begin : genTile
        ringTile #(
            .TILE_ID   (tile),
            .MEM_DEPTH (MEM_DEPTH)
        ) tile0 (
            .QClk      (QClk),
            .rstN      (rstN),
            .ringIn    (ringLink[tile]),
            .ringOut   (ringLink[tile+1])
        );
    end

endmodule

//--- hdl/ringGateway.sv
// host entry and exit of the ring, injects requests and extracts every message
`timescale 1ns/100ps

module ringGateway #(
    parameter int NUM_TILE = lotrCfgPkg::NUM_TILE_DEF      // tiles on the ring
) (
    input  logic                       QClk,
    input  logic                       rstN,
    // host requests
    input  logic                       reqValid,     // one-cycle strobe
    input  ringPkg::opcodeT            reqOpcode,
    input  logic [ringPkg::ADDR_W-1:0] reqAddress,
    input  logic [ringPkg::DATA_W-1:0] reqData,
    // ring side
    ringLinkIf.sender                  ringOut,      // link 0, toward tile 0
    ringLinkIf.receiver                ringIn,       // last link, from last tile
    // host responses
    output logic                       rspValid,     // one-cycle strobe
    output ringPkg::opcodeT            rspOpcode,
    output logic [ringPkg::ADDR_W-1:0] rspAddress,
    output logic [ringPkg::DATA_W-1:0] rspData,
    output logic                       rspMiss,      // came back unanswered
    // status
    output logic                       ringIdle
);

    // in flight: from accept until extraction, 2*NUM_TILE+2 cycles
    localparam int MAX_OUT = 2 * NUM_TILE + 2;
    localparam int CNT_W   = $clog2(MAX_OUT + 1);

    logic             reqAccept;
    logic [CNT_W-1:0] outCnt;       // requests on the ring

    function automatic logic isReq(ringPkg::opcodeT op);
        return (op == ringPkg::OP_RD_REQ) || (op == ringPkg::OP_WR_REQ);
    endfunction

    assign reqAccept = reqValid && isReq(reqOpcode);   // responses dropped

    //--------------------------------------------------
    // injection and extraction registers
    //--------------------------------------------------
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            ringOut.valid <= 1'b0;
            rspValid      <= 1'b0;
            rspMiss       <= 1'b0;
        end else begin
            ringOut.valid <= reqAccept;
            rspValid      <= ringIn.valid;          // slot always freed
            rspMiss       <= ringIn.valid && isReq(ringIn.opcode);
        end
    end

    always_ff @(posedge QClk) begin
        if (reqAccept) begin
            ringOut.opcode  <= reqOpcode;
            ringOut.address <= reqAddress;
            ringOut.data    <= reqData;
        end
        if (ringIn.valid) begin
            rspOpcode  <= ringIn.opcode;
            rspAddress <= ringIn.address;
            rspData    <= ringIn.data;
        end
    end

    // outstanding counter, inject and extract may coincide
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            outCnt <= '0;
        end else begin
            case ({reqAccept, ringIn.valid})
                2'b10:   outCnt <= outCnt + 1'b1;
                2'b01:   outCnt <= outCnt - 1'b1;
                default: outCnt <= outCnt;          // none or both
            endcase
        end
    end

    assign ringIdle = (outCnt == '0);

endmodule

//--- tile/ringTile.sv
// one ring stop, decode then execute then result, two cycles input to output
`timescale 1ns/100ps

module ringTile #(
    parameter int TILE_ID   = 0,                            // position on ring
    parameter int MEM_DEPTH = lotrCfgPkg::MEM_DEPTH_DEF
) (
    input  logic        QClk,
    input  logic        rstN,
    ringLinkIf.receiver ringIn,
    ringLinkIf.sender   ringOut
);

    //--------------------------------------------------
    // internal stage links
    //--------------------------------------------------
    ringLinkIf decLink ();      // decode -> execute
    ringLinkIf exeLink ();      // execute -> result

    logic                       decHit;
    logic                       exeHit;
    logic [ringPkg::DATA_W-1:0] exeRdData;

    // cycle n -> registered at end of n
    tileDecode #(
        .TILE_ID   (TILE_ID)
    ) decode0 (
        .QClk      (QClk),
        .rstN      (rstN),
        .ringIn    (ringIn),
        .decOut    (decLink),
        .decHit    (decHit)
    );

    // memory access at end of n+1
    tileExecute #(
        .MEM_DEPTH (MEM_DEPTH)
    ) execute0 (
        .QClk      (QClk),
        .rstN      (rstN),
        .decIn     (decLink),
        .decHit    (decHit),
        .exeOut    (exeLink),
        .exeHit    (exeHit),
        .exeRdData (exeRdData)
    );

    // comb, message out in n+2
    tileResult result0 (
        .exeIn     (exeLink),
        .exeHit    (exeHit),
        .exeRdData (exeRdData),
        .ringOut   (ringOut)
    );

endmodule

//--- tile/tileDecode.sv
// first tile stage, registers the ring message and flags requests for this tile
`timescale 1ns/100ps

module tileDecode #(
    parameter int TILE_ID = 0           // ring position of this tile
) (
    input  logic       QClk,
    input  logic       rstN,
    ringLinkIf.receiver ringIn,         // from previous ring stop
    ringLinkIf.sender   decOut,         // to execute stage
    output logic       decHit           // registered, aligned with decOut
);

    // width of the target field in the address
    localparam int ID_W = ringPkg::ID_MSB - ringPkg::ID_LSB + 1;
    localparam logic [ID_W-1:0] MY_ID = ID_W'(TILE_ID);

    logic isReq;        // still unanswered
    logic idMatch;      // address names this tile

    //--------------------------------------------------
    // hit decision
    //--------------------------------------------------
    assign isReq   = (ringIn.opcode == ringPkg::OP_RD_REQ) ||
                     (ringIn.opcode == ringPkg::OP_WR_REQ);
    assign idMatch = (ringIn.address[ringPkg::ID_MSB:ringPkg::ID_LSB] == MY_ID);

    //--------------------------------------------------
    // stage register
    //--------------------------------------------------
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            decOut.valid <= 1'b0;
            decHit       <= 1'b0;
        end else begin
            decOut.valid <= ringIn.valid;
            decHit       <= ringIn.valid && isReq && idMatch;
        end
    end

    // payload follows every cycle, qualified by valid downstream
    always_ff @(posedge QClk) begin
        decOut.opcode  <= ringIn.opcode;
        decOut.address <= ringIn.address;
        decOut.data    <= ringIn.data;
    end

endmodule

//--- tile/tileExecute.sv
// second tile stage that owns the tile memory and does the hit reads and writes for ringTile
`timescale 1ns/100ps

module tileExecute #(
    parameter int MEM_DEPTH = lotrCfgPkg::MEM_DEPTH_DEF    // words in this tile
) (
    input  logic                       QClk,
    input  logic                       rstN,
    ringLinkIf.receiver                decIn,      // from decode stage
    input  logic                       decHit,     // request targets this tile
    ringLinkIf.sender                  exeOut,     // to result stage
    output logic                       exeHit,
    output logic [ringPkg::DATA_W-1:0] exeRdData   // word read on a hit read
);

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    logic [ringPkg::DATA_W-1:0] mem [MEM_DEPTH];    // tile word memory
    logic [ringPkg::ID_LSB-1:0] wordAddr;           // word field under the tile number
    logic [IDX_W-1:0]           wordIdx;
    logic                       hitWr;
    logic                       hitRd;

    //--------------------------------------------------
    // address and access decode
    //--------------------------------------------------
    assign wordAddr = decIn.address[ringPkg::ID_LSB-1:0] >> ringPkg::WORD_LSB;
    assign wordIdx  = IDX_W'(wordAddr % MEM_DEPTH);   // wraps on depth

    assign hitWr = decHit && (decIn.opcode == ringPkg::OP_WR_REQ);
    assign hitRd = decHit && (decIn.opcode == ringPkg::OP_RD_REQ);

    // memory and read port
    always_ff @(posedge QClk) begin
        if (hitWr) begin
            mem[wordIdx] <= decIn.data;
        end
        if (hitRd) begin
            exeRdData <= mem[wordIdx];      // held until next hit read
        end
    end

    //--------------------------------------------------
    // stage register
    //--------------------------------------------------
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            exeOut.valid <= 1'b0;
            exeHit       <= 1'b0;
        end else begin
            exeOut.valid <= decIn.valid;
            exeHit       <= decHit;
        end
    end

    always_ff @(posedge QClk) begin
        exeOut.opcode  <= decIn.opcode;
        exeOut.address <= decIn.address;
        exeOut.data    <= decIn.data;     // write data kept for the echo
    end

endmodule

//--- tile/tileResult.sv
// last tile stage, turns a hit request into its response or forwards the message
`timescale 1ns/100ps

module tileResult (
    ringLinkIf.receiver                exeIn,      // from execute register
    input  logic                       exeHit,
    input  logic [ringPkg::DATA_W-1:0] exeRdData,
    ringLinkIf.sender                  ringOut     // to next ring stop
);

    logic isRead;

    assign isRead = (exeIn.opcode == ringPkg::OP_RD_REQ);

    //--------------------------------------------------
    // response build
    //--------------------------------------------------
    // purely combinational, output valid the cycle after execute
    always_comb begin
        ringOut.valid   = exeIn.valid;
        ringOut.address = exeIn.address;    // address never changes
        ringOut.opcode  = exeIn.opcode;
        ringOut.data    = exeIn.data;

        if (exeHit) begin
            if (isRead) begin
                ringOut.opcode = ringPkg::OP_RD_RSP;
                ringOut.data   = exeRdData;     // stored word
            end else begin
                ringOut.opcode = ringPkg::OP_WR_RSP;   // data echoed as is
            end
        end
    end

endmodule

//--- verification/lotrTb.sv
// directed testbench for the ring top level, run as the simulation top
`timescale 1ns/100ps

module lotrTb;

    localparam int NUM_TILE   = lotrCfgPkg::NUM_TILE_DEF;
    localparam int MEM_DEPTH  = lotrCfgPkg::MEM_DEPTH_DEF;
    localparam int LAT        = 2 + 2 * NUM_TILE;          // strobe to response
    localparam int TOTAL_REQ  = 2 * NUM_TILE + 24;         // all tests, rounded up
    localparam int WDOG_CYC   = (TOTAL_REQ + 10) * (2 * NUM_TILE + 4);

    logic                       QClk;
    logic                       rstN;
    logic                       reqValid;
    ringPkg::opcodeT            reqOpcode;
    logic [ringPkg::ADDR_W-1:0] reqAddress;
    logic [ringPkg::DATA_W-1:0] reqData;
    logic                       rspValid;
    ringPkg::opcodeT            rspOpcode;
    logic [ringPkg::ADDR_W-1:0] rspAddress;
    logic [ringPkg::DATA_W-1:0] rspData;
    logic                       rspMiss;
    logic                       ringIdle;

    int seed     = 40928;
    int cycleCnt = 0;

    // expected responses, oldest first
    ringPkg::opcodeT            expOp    [$];
    logic [ringPkg::ADDR_W-1:0] expAddr  [$];
    logic [ringPkg::DATA_W-1:0] expData  [$];
    logic                       expMiss  [$];
    int                         expCycle [$];  // cycle the response must show

    logic [ringPkg::DATA_W-1:0] memModel [NUM_TILE][MEM_DEPTH];

    tbClockGen clkGen0 (.QClk(QClk), .rstN(rstN));

    lotr dut0 (
        .QClk       (QClk),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .reqOpcode  (reqOpcode),
        .reqAddress (reqAddress),
        .reqData    (reqData),
        .rspValid   (rspValid),
        .rspOpcode  (rspOpcode),
        .rspAddress (rspAddress),
        .rspData    (rspData),
        .rspMiss    (rspMiss),
        .ringIdle   (ringIdle)
    );

    always @(posedge QClk) cycleCnt <= cycleCnt + 1;

    //--------------------------------------------------
    // failure reporting and compare tasks
    //--------------------------------------------------
    task automatic stopOnFailure();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic failWithReason(string why);
        $display("%s at %0t", why, $time);
        stopOnFailure();
    endtask

    task automatic checkOpcode(string sig, ringPkg::opcodeT expVal, ringPkg::opcodeT actVal);
        if (actVal !== expVal) begin
            $display("ERROR at %0t: %s expected %b got %b", $time, sig, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic checkWord(string sig, logic [ringPkg::DATA_W-1:0] expVal,
                             logic [ringPkg::DATA_W-1:0] actVal);  // address too, same width
        if (actVal !== expVal) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, sig, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic checkBit(string sig, logic expVal, logic actVal);
        if (actVal !== expVal) begin
            $display("ERROR at %0t: %s expected %b got %b", $time, sig, expVal, actVal);
            stopOnFailure();
        end
    endtask

    //--------------------------------------------------
    // reference model
    //--------------------------------------------------
    function automatic logic [ringPkg::ADDR_W-1:0] makeAddr(int tile, int word);
        return (ringPkg::ADDR_W'(tile) << ringPkg::ID_LSB) |
               (ringPkg::ADDR_W'(word) << ringPkg::WORD_LSB);
    endfunction

    // outstanding from the cycle after the strobe until the response cycle
    function automatic bit expectIdle();
        foreach (expCycle[i]) begin
            if ((expCycle[i] - LAT < cycleCnt) && (cycleCnt < expCycle[i])) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic predictResponse(ringPkg::opcodeT op, logic [ringPkg::ADDR_W-1:0] addr,
                                   logic [ringPkg::DATA_W-1:0] data);
        int tile;
        int word;
        tile = addr[ringPkg::ID_MSB:ringPkg::ID_LSB];
        word = addr[ringPkg::ID_LSB-1:ringPkg::WORD_LSB] % MEM_DEPTH;
        if (op != ringPkg::OP_RD_REQ && op != ringPkg::OP_WR_REQ) return;  // dropped
        expAddr.push_back(addr);
        expCycle.push_back(cycleCnt + LAT);
        if (tile >= NUM_TILE) begin         // nobody answers, comes back as is
            expOp.push_back(op);
            expData.push_back(data);
            expMiss.push_back(1'b1);
        end else if (op == ringPkg::OP_WR_REQ) begin
            memModel[tile][word] = data;
            expOp.push_back(ringPkg::OP_WR_RSP);
            expData.push_back(data);
            expMiss.push_back(1'b0);
        end else begin
            expOp.push_back(ringPkg::OP_RD_RSP);
            expData.push_back(memModel[tile][word]);
            expMiss.push_back(1'b0);
        end
    endtask

    //--------------------------------------------------
    // response monitor, samples at the falling edge
    //--------------------------------------------------
    always @(negedge QClk) begin
        if (rstN) begin
            if (rspValid && expOp.size() == 0) begin
                failWithReason("response arrived while no request was outstanding");
            end else if (rspValid) begin
                if (expCycle[0] != cycleCnt) begin
                    $display("ERROR at %0t: response cycle expected %0d got %0d",
                             $time, expCycle[0], cycleCnt);
                    stopOnFailure();
                end
                checkOpcode("rspOpcode", expOp.pop_front(), rspOpcode);
                checkWord("rspAddress", expAddr.pop_front(), rspAddress);
                checkWord("rspData", expData.pop_front(), rspData);
                checkBit("rspMiss", expMiss.pop_front(), rspMiss);
                void'(expCycle.pop_front());
            end else begin
                checkBit("rspMiss", 1'b0, rspMiss);
                if (expOp.size() != 0 && expCycle[0] < cycleCnt) begin
                    failWithReason("expected response never arrived");
                end
            end
            checkBit("ringIdle", expectIdle(), ringIdle);
        end
    end

    // hard stop for a hung run
    initial begin
        repeat (WDOG_CYC) @(posedge QClk);
        $display("watchdog expired after %0d cycles", WDOG_CYC);
        stopOnFailure();
    end

    //--------------------------------------------------
    // stimulus helpers
    //--------------------------------------------------
    task automatic strobeReq(ringPkg::opcodeT op, logic [ringPkg::ADDR_W-1:0] addr,
                             logic [ringPkg::DATA_W-1:0] data);
        @(negedge QClk);
        reqValid   = 1'b1;
        reqOpcode  = op;
        reqAddress = addr;
        reqData    = data;
        predictResponse(op, addr, data);
    endtask

    task automatic releaseReq();
        @(negedge QClk);
        reqValid = 1'b0;
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expOp.size() != 0) begin
            @(negedge QClk);
            waited++;
            if (waited > LAT + 4) failWithReason("timed out waiting for responses");
        end
    endtask

    task automatic sendAndWait(ringPkg::opcodeT op, logic [ringPkg::ADDR_W-1:0] addr,
                               logic [ringPkg::DATA_W-1:0] data);
        strobeReq(op, addr, data);
        releaseReq();
        waitDrain();
    endtask

    //--------------------------------------------------
    // directed tests
    //--------------------------------------------------
    task automatic testResetState();
        checkBit("rspValid", 1'b0, rspValid);
        checkBit("rspMiss", 1'b0, rspMiss);
        checkBit("ringIdle", 1'b1, ringIdle);
    endtask

    task automatic testWriteReadAll();
        int word;
        for (int t = 0; t < NUM_TILE; t++) begin
            word = $unsigned($random(seed)) % MEM_DEPTH;
            sendAndWait(ringPkg::OP_WR_REQ, makeAddr(t, word), $random(seed));
            sendAndWait(ringPkg::OP_RD_REQ, makeAddr(t, word), $random(seed)); // data ignored
        end
    endtask

    task automatic testMiss();
        sendAndWait(ringPkg::OP_RD_REQ, makeAddr(NUM_TILE, 3), $random(seed));
        sendAndWait(ringPkg::OP_WR_REQ, makeAddr(NUM_TILE + 1, 9), $random(seed));
        sendAndWait(ringPkg::OP_WR_REQ, makeAddr(8'hFF, 0), $random(seed));
    endtask

    task automatic testBurst();
        int last;
        last = NUM_TILE - 1;
        for (int t = 0; t < NUM_TILE; t++) begin
            strobeReq(ringPkg::OP_WR_REQ, makeAddr(t, (5 + t) % MEM_DEPTH), $random(seed));
        end
        strobeReq(ringPkg::OP_RD_REQ, makeAddr(NUM_TILE + 1, 2), $random(seed));
        for (int t = 0; t < NUM_TILE; t++) begin
            strobeReq(ringPkg::OP_RD_REQ, makeAddr(t, (5 + t) % MEM_DEPTH), $random(seed));
        end
        // word index wraps onto the same location
        strobeReq(ringPkg::OP_WR_REQ, makeAddr(last, (5 + last) % MEM_DEPTH + MEM_DEPTH),
                  $random(seed));
        strobeReq(ringPkg::OP_RD_REQ, makeAddr(last, (5 + last) % MEM_DEPTH), $random(seed));
        strobeReq(ringPkg::OP_WR_REQ, makeAddr(8'hFF, 1), $random(seed));
        releaseReq();
        waitDrain();
    endtask

    task automatic testIdle();
        strobeReq(ringPkg::OP_RD_REQ, makeAddr(0, 5), $random(seed));
        releaseReq();
        checkBit("ringIdle", 1'b0, ringIdle);
        waitDrain();
        checkBit("ringIdle", 1'b1, ringIdle);
    endtask

    task automatic testDropResponse();
        strobeReq(ringPkg::OP_RD_RSP, makeAddr(1, 2), $random(seed));
        strobeReq(ringPkg::OP_WR_RSP, makeAddr(2, 3), $random(seed));
        releaseReq();
        repeat (LAT + 2) @(negedge QClk);   // monitor flags any response
        checkBit("ringIdle", 1'b1, ringIdle);
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 10);
        reqValid   = 1'b0;
        reqOpcode  = ringPkg::OP_RD_REQ;
        reqAddress = '0;
        reqData    = '0;
        wait (rstN === 1'b1);
        @(negedge QClk);
        testResetState();
        testWriteReadAll();
        testMiss();
        testBurst();
        testIdle();
        testDropResponse();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- verification/lotr_props.sv
// gateway protocol assertions, bound into every ringGateway instance
`timescale 1ns/100ps

module lotrProps (
    input logic            QClk,
    input logic            rstN,
    input logic            rspValid,
    input logic            rspMiss,
    input ringPkg::opcodeT rspOpcode,
    input logic            linkOutValid,    // link 0 valid
    input logic            linkInValid      // last link valid
);

    //--------------------------------------------------
    // response port
    //--------------------------------------------------
    // a miss is only flagged on a real response
    missNeedsValid: assert property (@(posedge QClk) disable iff (!rstN)
        rspMiss |-> rspValid)
        else $error("rspMiss high without rspValid");

    // answered messages must carry a response opcode
    hitIsResponse: assert property (@(posedge QClk) disable iff (!rstN)
        (rspValid && !rspMiss) |->
            (rspOpcode inside {ringPkg::OP_RD_RSP, ringPkg::OP_WR_RSP}))
        else $error("answered response with request opcode %b", rspOpcode);

    //--------------------------------------------------
    // ring links
    //--------------------------------------------------
    validKnown: assert property (@(posedge QClk) disable iff (!rstN)
        !$isunknown({linkOutValid, linkInValid}))
        else $error("ring valid unknown at gateway");

endmodule

bind ringGateway lotrProps props0 (
    .QClk         (QClk),
    .rstN         (rstN),
    .rspValid     (rspValid),
    .rspMiss      (rspMiss),
    .rspOpcode    (rspOpcode),
    .linkOutValid (ringOut.valid),
    .linkInValid  (ringIn.valid)
);

//--- verification/tbClockGen.sv
// testbench clock and reset source, instantiated once by the ring testbench
`timescale 1ns/100ps

module tbClockGen #(
    parameter int PERIOD_NS  = 100,     // full clock period
    parameter int RST_CYCLES = 8        // cycles held in reset
) (
    output logic QClk,
    output logic rstN
);

    // free running clock, starts low
    initial begin
        QClk = 1'b0;
        forever #(PERIOD_NS / 2) QClk = ~QClk;
    end

    initial begin
        rstN = 1'b0;
        repeat (RST_CYCLES) @(posedge QClk);
        @(negedge QClk);                // release away from the active edge
        rstN = 1'b1;
    end

endmodule

//--- vlog.f
common/ringPkg.sv
common/lotrCfgPkg.sv
common/ringLinkIf.sv
tile/tileDecode.sv
tile/tileExecute.sv
tile/tileResult.sv
tile/ringTile.sv
hdl/ringGateway.sv
hdl/lotr.sv
verification/tbClockGen.sv
verification/lotr_props.sv
verification/lotrTb.sv
